/* avr_pkg.sv */
// AVR core shared definitions
package avr_pkg;

   // **************************************************
   // Sizes
   // **************************************************
   localparam int data_w    = 8;
   localparam int pc_w      = 16;
   localparam int inst_w    = 16;
   localparam int reg_cnt   = 32;
   localparam int reg_adr_w = 5;
   localparam int io_adr_w  = 6;

   // Status register bit positions
   localparam int flag_c = 0;
   localparam int flag_z = 1;
   localparam int flag_n = 2;
   localparam int flag_v = 3;
   localparam int flag_s = 4;
   localparam int flag_h = 5;

   typedef logic [data_w-1:0]    data_t;
   typedef logic [reg_adr_w-1:0] reg_adr_t;
   typedef logic [io_adr_w-1:0]  io_adr_t;
   typedef logic [7:0]           sreg_t;

   // **************************************************
   // Decoded instruction
   // **************************************************
   typedef enum logic [4:0] {
      op_nop,
      op_add, op_adc, op_sub, op_sbc, op_and,
      op_or, op_eor, op_mov, op_cp,
      op_subi, op_andi, op_ori, op_cpi, op_ldi,
      op_com, op_neg, op_inc, op_dec,
      op_lsr, op_ror, op_asr, op_swap,
      op_out
   } alu_op_t;

   // 29 bits in all
   typedef struct packed {
      alu_op_t  op;
      reg_adr_t rd_adr;
      reg_adr_t rr_adr;
      data_t    imm;
      io_adr_t  io_adr;
   } dec_inst_t;

endpackage

/* avr_if.sv */
// AVR core internal buses
`timescale 1ns/10ps

// Decoded instruction from fetch to execute
interface dec_if import avr_pkg::*; ();

   dec_inst_t inst;
   logic      valid;

   modport producer (output inst, output valid);
   modport consumer (input inst, input valid);

endinterface

// Register file port, Rd doubles as the write address
interface rf_if import avr_pkg::*; ();

   reg_adr_t rd_adr;
   reg_adr_t rr_adr;
   data_t    rd_data;
   data_t    rr_data;
   logic     wr_en;
   data_t    wr_data;

   modport user (
      output rd_adr,
      output rr_adr,
      output wr_en,
      output wr_data,
      input  rd_data,
      input  rr_data
   );

   modport storage (
      input  rd_adr,
      input  rr_adr,
      input  wr_en,
      input  wr_data,
      output rd_data,
      output rr_data
   );

endinterface

/* avr_fetch_dec.sv */
// AVR program counter and decoder
`timescale 1ns/10ps

module avr_fetch_dec import avr_pkg::*;
(
   input  logic            cp2,
   input  logic            rst_n,
   input  logic            cp2en,
   output logic [pc_w-1:0] pc,
   input  logic [inst_w-1:0] inst,
   dec_if.producer         dec
);

   dec_inst_t dec_nxt;

   // **************************************************
   // Opcode decode
   // **************************************************
   always_comb
   begin
      dec_nxt.op     = op_nop;
      dec_nxt.rd_adr = inst[8:4];
      dec_nxt.rr_adr = {inst[9], inst[3:0]};
      dec_nxt.imm    = {inst[11:8], inst[3:0]};
      dec_nxt.io_adr = {inst[10:9], inst[3:0]};

      casez (inst)
         // Two-register forms
         16'b0000_11??_????_????: dec_nxt.op = op_add;
         16'b0001_11??_????_????: dec_nxt.op = op_adc;
         16'b0001_10??_????_????: dec_nxt.op = op_sub;
         16'b0000_10??_????_????: dec_nxt.op = op_sbc;
         16'b0010_00??_????_????: dec_nxt.op = op_and;
         16'b0010_10??_????_????: dec_nxt.op = op_or;
         16'b0010_01??_????_????: dec_nxt.op = op_eor;
         16'b0010_11??_????_????: dec_nxt.op = op_mov;
         16'b0001_01??_????_????: dec_nxt.op = op_cp;
         // Immediate forms
         16'b0101_????_????_????: dec_nxt.op = op_subi;
         16'b0111_????_????_????: dec_nxt.op = op_andi;
         16'b0110_????_????_????: dec_nxt.op = op_ori;
         16'b0011_????_????_????: dec_nxt.op = op_cpi;
         16'b1110_????_????_????: dec_nxt.op = op_ldi;
         // Single-register forms
         16'b1001_010?_????_0000: dec_nxt.op = op_com;
         16'b1001_010?_????_0001: dec_nxt.op = op_neg;
         16'b1001_010?_????_0010: dec_nxt.op = op_swap;
         16'b1001_010?_????_0011: dec_nxt.op = op_inc;
         16'b1001_010?_????_0101: dec_nxt.op = op_asr;
         16'b1001_010?_????_0110: dec_nxt.op = op_lsr;
         16'b1001_010?_????_0111: dec_nxt.op = op_ror;
         16'b1001_010?_????_1010: dec_nxt.op = op_dec;
         // OUT A,Rr
         16'b1011_1???_????_????: dec_nxt.op = op_out;
         default:                 dec_nxt.op = op_nop;
      endcase

      // Immediate forms only reach R16..R31
      if (dec_nxt.op inside {op_subi, op_andi, op_ori, op_cpi, op_ldi})
      begin
         dec_nxt.rd_adr = {1'b1, inst[7:4]};
      end
   end

   // **************************************************
   // PC and decode register
   // **************************************************
   always_ff @(posedge cp2 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pc        <= '0;
         dec.valid <= 1'b0;
         dec.inst  <= '0;
      end
      else if (cp2en)
      begin
         pc        <= pc + 1'b1;
         dec.valid <= 1'b1;
         dec.inst  <= dec_nxt;
      end
   end

   // Linear fetch, one word per enabled edge
   a_pc_step : assert property (@(posedge cp2) disable iff (!rst_n)
      cp2en |=> pc == $past(pc) + 1'b1);

endmodule

/* avr_reg_file.sv */
// AVR working register file
`timescale 1ns/10ps

module avr_reg_file import avr_pkg::*;
(
   input  logic      cp2,
   input  logic      rst_n,
   input  logic      cp2en,
   rf_if.storage     rf
);

   data_t regs [reg_cnt];

   // Write port, destination is Rd
   always_ff @(posedge cp2 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         foreach (regs[i])
         begin
            regs[i] <= '0;
         end
      end
      else if (cp2en && rf.wr_en)
      begin
         regs[rf.rd_adr] <= rf.wr_data;
      end
   end

   // Combinational reads
   assign rf.rd_data = regs[rf.rd_adr];
   assign rf.rr_data = regs[rf.rr_adr];

   // Write enable comes from the execute stage decode
   a_wr_en_known : assert property (@(posedge cp2) disable iff (!rst_n)
      !$isunknown(rf.wr_en));

endmodule

/* avr_alu_exec.sv */
// AVR ALU and execute stage
`timescale 1ns/10ps

module avr_alu_exec import avr_pkg::*;
(
   input  logic      cp2,
   input  logic      rst_n,
   input  logic      cp2en,
   dec_if.consumer   dec,
   rf_if.user        rf,
   output sreg_t     sreg,
   output io_adr_t   adr,
   output logic      iowe,
   output data_t     dbusout
);

   alu_op_t    op;
   data_t      rd_val;
   data_t      rr_val;
   data_t      add_a;
   data_t      add_b;
   logic       add_cin;
   logic       add_sub;
   logic [8:0] add_res;
   logic       add_h;
   logic       add_v;
   data_t      alu_res;
   sreg_t      sreg_nxt;
   logic       res_we;
   logic       flag_we;
   logic       out_hit;

   assign op        = dec.inst.op;
   assign rf.rd_adr = dec.inst.rd_adr;
   assign rf.rr_adr = dec.inst.rr_adr;
   assign rd_val    = rf.rd_data;
   assign rr_val    = (op inside {op_subi, op_andi, op_ori, op_cpi, op_ldi}) ?
                      dec.inst.imm : rf.rr_data;

   // **************************************************
   // Shared adder
   // **************************************************
   always_comb
   begin
      add_a   = rd_val;
      add_b   = rr_val;
      add_cin = 1'b0;
      add_sub = 1'b0;
      case (op)
         op_adc:                        add_cin = sreg[flag_c];
         op_sub, op_subi, op_cp, op_cpi: add_sub = 1'b1;
         op_sbc:
         begin
            add_sub = 1'b1;
            add_cin = sreg[flag_c];
         end
         // NEG is 0 - Rd
         op_neg:
         begin
            add_a   = '0;
            add_b   = rd_val;
            add_sub = 1'b1;
         end
         op_inc:
         begin
            add_b   = '0;
            add_cin = 1'b1;
         end
         op_dec:
         begin
            add_b   = '0;
            add_cin = 1'b1;
            add_sub = 1'b1;
         end
         default: ;
      endcase
   end

   assign add_res = add_sub ? {1'b0, add_a} - {1'b0, add_b} - {8'b0, add_cin}
                            : {1'b0, add_a} + {1'b0, add_b} + {8'b0, add_cin};

   // Half carry and overflow with borrow sense for subtraction
   assign add_h = add_sub ?
      (~add_a[3] & add_b[3]) | (add_b[3] & add_res[3]) | (add_res[3] & ~add_a[3]) :
      (add_a[3] & add_b[3]) | (add_b[3] & ~add_res[3]) | (~add_res[3] & add_a[3]);
   assign add_v = add_sub ?
      (add_a[7] & ~add_b[7] & ~add_res[7]) | (~add_a[7] & add_b[7] & add_res[7]) :
      (add_a[7] & add_b[7] & ~add_res[7]) | (~add_a[7] & ~add_b[7] & add_res[7]);

   // **************************************************
   // Result and flags
   // **************************************************
   always_comb
   begin
      alu_res  = add_res[7:0];
      sreg_nxt = sreg;
      sreg_nxt[flag_v] = 1'b0;
      res_we   = 1'b1;
      flag_we  = 1'b1;
      case (op)
         op_add, op_adc, op_sub, op_sbc, op_subi, op_neg, op_cp, op_cpi:
         begin
            sreg_nxt[flag_c] = add_res[8];
            sreg_nxt[flag_h] = add_h;
            sreg_nxt[flag_v] = add_v;
            res_we           = !(op inside {op_cp, op_cpi});
         end
         // Carry untouched
         op_inc, op_dec: sreg_nxt[flag_v] = add_v;
         op_and, op_andi: alu_res = rd_val & rr_val;
         op_or, op_ori:   alu_res = rd_val | rr_val;
         op_eor:          alu_res = rd_val ^ rf.rr_data;
         op_com:
         begin
            alu_res          = ~rd_val;
            sreg_nxt[flag_c] = 1'b1;
         end
         op_lsr, op_ror, op_asr:
         begin
            if (op == op_lsr)
               alu_res = {1'b0, rd_val[7:1]};
            else if (op == op_ror)
               alu_res = {sreg[flag_c], rd_val[7:1]};
            else
               alu_res = {rd_val[7], rd_val[7:1]};
            sreg_nxt[flag_c] = rd_val[0];
            sreg_nxt[flag_v] = alu_res[7] ^ rd_val[0];
         end
         // Plain moves leave the flags alone
         op_mov, op_ldi:
         begin
            alu_res = rr_val;
            flag_we = 1'b0;
         end
         op_swap:
         begin
            alu_res = {rd_val[3:0], rd_val[7:4]};
            flag_we = 1'b0;
         end
         default:
         begin
            res_we  = 1'b0;
            flag_we = 1'b0;
         end
      endcase

      sreg_nxt[flag_n] = alu_res[7];
      // SBC keeps Z only across a zero chain
      sreg_nxt[flag_z] = (alu_res == '0) && (op != op_sbc || sreg[flag_z]);
      sreg_nxt[flag_s] = sreg_nxt[flag_n] ^ sreg_nxt[flag_v];
   end

   assign rf.wr_en   = dec.valid && res_we;
   assign rf.wr_data = alu_res;
   assign out_hit    = cp2en && dec.valid && op == op_out;

   // **************************************************
   // Status register and I/O strobe
   // **************************************************
   always_ff @(posedge cp2 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sreg <= '0;
         iowe <= 1'b0;
      end
      else
      begin
         iowe <= out_hit;
         if (cp2en && dec.valid && flag_we)
            sreg <= sreg_nxt;
      end
   end

   always_ff @(posedge cp2)
   begin
      if (out_hit)
      begin
         adr     <= dec.inst.io_adr;
         dbusout <= rd_val;
      end
   end

   // Each strobe carries the OUT taken at the previous enabled edge
   a_iowe_src : assert property (@(posedge cp2) disable iff (!rst_n)
      iowe |-> $past(out_hit) && adr == $past(dec.inst.io_adr)
               && dbusout == $past(rd_val));

   // A pulse ends after one clock unless another OUT follows straight on
   a_iowe_one : assert property (@(posedge cp2) disable iff (!rst_n)
      iowe && !(dec.valid && op == op_out) |=> !iowe);

endmodule

/* avr_core.sv */
// AVR core top level
`timescale 1ns/10ps

module avr_core
(
   // Clock and reset
   input  logic        cp2,
   input  logic        rst_n,
   input  logic        cp2en,
   // Program memory
   output logic [15:0] pc,
   input  logic [15:0] inst,
   // I/O write
   output logic [5:0]  adr,
   output logic        iowe,
   output logic [7:0]  dbusout,
   output logic [7:0]  sreg
);

   dec_if dec_bus ();
   rf_if  rf_bus ();

   // Fetch and decode
   avr_fetch_dec fetch_dec_inst (
      .cp2   (cp2),
      .rst_n (rst_n),
      .cp2en (cp2en),
      .pc    (pc),
      .inst  (inst),
      .dec   (dec_bus.producer)
   );

   avr_reg_file gprf_inst (
      .cp2   (cp2),
      .rst_n (rst_n),
      .cp2en (cp2en),
      .rf    (rf_bus.storage)
   );

   // Execute and write-back
   avr_alu_exec alu_exec_inst (
      .cp2     (cp2),
      .rst_n   (rst_n),
      .cp2en   (cp2en),
      .dec     (dec_bus.consumer),
      .rf      (rf_bus.user),
      .sreg    (sreg),
      .adr     (adr),
      .iowe    (iowe),
      .dbusout (dbusout)
   );

endmodule

/* tb_avr_core.sv */
// AVR core testbench
`timescale 1ns/10ps

module tb_avr_core import avr_pkg::*;;

   logic             cp2;
   logic             rst_n;
   logic             cp2en;
   logic [pc_w-1:0]  pc;
   logic [inst_w-1:0] inst;
   io_adr_t          adr;
   logic             iowe;
   data_t            dbusout;
   sreg_t            sreg;

   integer seed = 32'h6831_0788;
   int     errors = 0;
   int     checks = 0;
   int     tests = 0;
   int     err_start;
   int     stall_pct;
   logic   out_seen;

   // Reference model state
   data_t           mreg [reg_cnt];
   sreg_t           msreg;
   logic [pc_w-1:0] mpc;
   logic            exp_iowe;
   io_adr_t         exp_adr;
   data_t           exp_dbus;
   // Word at the fetch port and the one stage behind it
   alu_op_t c_op;
   int      c_d;
   int      c_r;
   int      c_k;
   int      c_a;
   logic    s_valid;
   alu_op_t s_op;
   int      s_d;
   int      s_r;
   int      s_k;
   int      s_a;

   alu_op_t two_ops [9] = '{op_add, op_adc, op_sub, op_sbc, op_and,
                            op_or, op_eor, op_mov, op_cp};
   alu_op_t imm_ops [5] = '{op_subi, op_andi, op_ori, op_cpi, op_ldi};
   alu_op_t one_ops [8] = '{op_com, op_neg, op_inc, op_dec,
                            op_lsr, op_ror, op_asr, op_swap};

   avr_core UUT (
      .cp2     (cp2),
      .rst_n   (rst_n),
      .cp2en   (cp2en),
      .pc      (pc),
      .inst    (inst),
      .adr     (adr),
      .iowe    (iowe),
      .dbusout (dbusout),
      .sreg    (sreg)
   );

   initial
   begin
      cp2 = 1'b0;
      forever #2 cp2 = ~cp2;
   end

   // **************************************************
   // Compare tasks
   // **************************************************
   task automatic check_data(input string name, input data_t got, input data_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_sreg(input string name, input sreg_t got, input sreg_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_adr(input string name, input io_adr_t got, input io_adr_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_pc(input string name, input logic [pc_w-1:0] got,
                           input logic [pc_w-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   function automatic int rnd(input int n);
      rnd = ($random(seed) & 32'h7fff_ffff) % n;
   endfunction

   // AVR instruction word from its fields
   function automatic logic [15:0] encode(input alu_op_t op, input int d, input int r,
                                          input int k, input int a);
      reg_adr_t dd;
      reg_adr_t rr;
      data_t    kk;
      io_adr_t  aa;
      dd = reg_adr_t'(d);
      rr = reg_adr_t'(r);
      kk = data_t'(k);
      aa = io_adr_t'(a);
      case (op)
         op_add:  encode = {6'b000011, rr[4], dd, rr[3:0]};
         op_adc:  encode = {6'b000111, rr[4], dd, rr[3:0]};
         op_sub:  encode = {6'b000110, rr[4], dd, rr[3:0]};
         op_sbc:  encode = {6'b000010, rr[4], dd, rr[3:0]};
         op_and:  encode = {6'b001000, rr[4], dd, rr[3:0]};
         op_or:   encode = {6'b001010, rr[4], dd, rr[3:0]};
         op_eor:  encode = {6'b001001, rr[4], dd, rr[3:0]};
         op_mov:  encode = {6'b001011, rr[4], dd, rr[3:0]};
         op_cp:   encode = {6'b000101, rr[4], dd, rr[3:0]};
         op_subi: encode = {4'b0101, kk[7:4], dd[3:0], kk[3:0]};
         op_andi: encode = {4'b0111, kk[7:4], dd[3:0], kk[3:0]};
         op_ori:  encode = {4'b0110, kk[7:4], dd[3:0], kk[3:0]};
         op_cpi:  encode = {4'b0011, kk[7:4], dd[3:0], kk[3:0]};
         op_ldi:  encode = {4'b1110, kk[7:4], dd[3:0], kk[3:0]};
         op_com:  encode = {7'b1001010, dd, 4'b0000};
         op_neg:  encode = {7'b1001010, dd, 4'b0001};
         op_swap: encode = {7'b1001010, dd, 4'b0010};
         op_inc:  encode = {7'b1001010, dd, 4'b0011};
         op_asr:  encode = {7'b1001010, dd, 4'b0101};
         op_lsr:  encode = {7'b1001010, dd, 4'b0110};
         op_ror:  encode = {7'b1001010, dd, 4'b0111};
         op_dec:  encode = {7'b1001010, dd, 4'b1010};
         op_out:  encode = {5'b10111, aa[5:4], dd, aa[3:0]};
         // Unknown codes from unused opcode groups
         default: encode = {aa[0] ? 4'b1111 : 4'b1000, kk, aa[5:2]};
      endcase
   endfunction

   // **************************************************
   // Reference model with one instruction per enabled edge
   // **************************************************
   task automatic model_exec(input alu_op_t op, input int d, input int r,
                             input int k, input int a);
      data_t x;
      data_t y;
      data_t res;
      int    cin;
      logic  wr;
      logic  fl;
      logic  v;
      sreg_t s;
      s   = msreg;
      x   = mreg[d];
      y   = (op inside {op_subi, op_andi, op_ori, op_cpi, op_ldi}) ? data_t'(k) : mreg[r];
      res = '0;
      cin = 0;
      wr  = 1'b1;
      fl  = 1'b1;
      v   = 1'b0;
      case (op)
         op_add, op_adc:
         begin
            cin = (op == op_adc) ? int'(msreg[flag_c]) : 0;
            res = x + y + cin;
            s[flag_c] = (int'(x) + int'(y) + cin) > 255;
            s[flag_h] = (int'(x[3:0]) + int'(y[3:0]) + cin) > 15;
            v = (x[7] == y[7]) && (res[7] != x[7]);
         end
         op_sub, op_subi, op_sbc, op_cp, op_cpi, op_neg:
         begin
            if (op == op_neg)
            begin
               y = x;
               x = '0;
            end
            cin = (op == op_sbc) ? int'(msreg[flag_c]) : 0;
            res = x - y - cin;
            s[flag_c] = int'(x) < int'(y) + cin;
            s[flag_h] = int'(x[3:0]) < int'(y[3:0]) + cin;
            v  = (x[7] != y[7]) && (res[7] != x[7]);
            wr = !(op inside {op_cp, op_cpi});
         end
         op_inc:
         begin
            res = x + 1;
            v   = (x == 8'h7f);
         end
         op_dec:
         begin
            res = x - 1;
            v   = (x == 8'h80);
         end
         op_and, op_andi: res = x & y;
         op_or, op_ori:   res = x | y;
         op_eor:          res = x ^ y;
         op_com:
         begin
            res = ~x;
            s[flag_c] = 1'b1;
         end
         op_lsr, op_ror, op_asr:
         begin
            res = x >> 1;
            if (op == op_ror)
               res[7] = msreg[flag_c];
            if (op == op_asr)
               res[7] = x[7];
            s[flag_c] = x[0];
            v = res[7] ^ x[0];
         end
         op_mov, op_ldi:
         begin
            res = y;
            fl  = 1'b0;
         end
         op_swap:
         begin
            res = {x[3:0], x[7:4]};
            fl  = 1'b0;
         end
         op_out:
         begin
            wr       = 1'b0;
            fl       = 1'b0;
            exp_iowe = 1'b1;
            exp_adr  = io_adr_t'(a);
            exp_dbus = x;
         end
         default:
         begin
            wr = 1'b0;
            fl = 1'b0;
         end
      endcase
      if (fl)
      begin
         s[flag_v] = v;
         s[flag_n] = res[7];
         s[flag_z] = (res == 0) && (op != op_sbc || msreg[flag_z]);
         s[flag_s] = res[7] ^ v;
         msreg     = s;
      end
      if (wr)
         mreg[d] = res;
   endtask

   // One clock with inputs set on the falling edge and outputs checked after the rising one
   task automatic tick(input logic en);
      cp2en = en;
      inst  = encode(c_op, c_d, c_r, c_k, c_a);
      @(posedge cp2);
      @(negedge cp2);
      exp_iowe = 1'b0;
      if (en)
      begin
         if (s_valid)
            model_exec(s_op, s_d, s_r, s_k, s_a);
         s_valid = 1'b1;
         s_op    = c_op;
         s_d     = c_d;
         s_r     = c_r;
         s_k     = c_k;
         s_a     = c_a;
         mpc     = mpc + 1'b1;
      end
      check_pc("pc", pc, mpc);
      check_sreg("sreg", sreg, msreg);
      check_bit("iowe", iowe, exp_iowe);
      if (exp_iowe)
      begin
         check_adr("adr", adr, exp_adr);
         check_data("dbusout", dbusout, exp_dbus);
      end
      if (iowe === 1'b1)
         out_seen = 1'b1;
   endtask

   // Present one word until an enabled edge takes it
   task automatic issue(input alu_op_t op, input int d, input int r,
                        input int k, input int a);
      int   stalls;
      logic en;
      c_op   = op;
      c_d    = d;
      c_r    = r;
      c_k    = k;
      c_a    = a;
      stalls = 0;
      en     = 1'b0;
      while (!en)
      begin
         en = !(rnd(100) < stall_pct && stalls < 8);
         stalls++;
         tick(en);
      end
   endtask

   task automatic wait_out();
      int n;
      int k;
      int a;
      n        = 0;
      out_seen = 1'b0;
      while (!out_seen && n < 16)
      begin
         k = rnd(256);
         a = rnd(64);
         issue(op_nop, 0, 0, k, a);
         n++;
      end
      if (!out_seen)
      begin
         errors++;
         $display("timeout at %0t: no iowe pulse within 16 instructions", $time);
      end
   endtask

   // Every register leaves through OUT
   task automatic dump_regs();
      for (int i = 0; i < reg_cnt; i++)
         issue(op_out, i, 0, 0, i);
      wait_out();
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s done, %0d errors", tests, name, errors - err_start);
      err_start = errors;
   endtask

   // **************************************************
   // Test sequence
   // **************************************************
   initial
   begin
      int d;
      int r;
      int k;
      int a;
      int sel;
      int last_d;
      rst_n     = 1'b0;
      cp2en     = 1'b0;
      inst      = '0;
      err_start = 0;
      stall_pct = 0;
      foreach (mreg[i])
         mreg[i] = '0;
      msreg   = '0;
      mpc     = '0;
      s_valid = 1'b0;
      c_op    = op_nop;
      c_d     = 0;
      c_r     = 0;
      c_k     = 0;
      c_a     = 0;
      last_d  = 0;
      repeat (3) @(posedge cp2);
      @(negedge cp2);
      rst_n = 1'b1;

      check_pc("pc", pc, '0);
      check_bit("iowe", iowe, 1'b0);
      check_sreg("sreg", sreg, '0);
      stall_pct = 40;
      for (int i = 0; i < 20; i++)
         issue(op_nop, 0, 0, 0, 0);
      end_test("reset and pc");

      stall_pct = 20;
      for (int i = 0; i < 12; i++)
      begin
         d = 16 + rnd(16);
         k = rnd(256);
         a = rnd(64);
         issue(op_ldi, d, 0, k, 0);
         issue(op_out, d, 0, 0, a);
         wait_out();
      end
      end_test("ldi and out");

      for (int i = 0; i < 200; i++)
      begin
         sel = rnd(10);
         d   = rnd(32);
         r   = rnd(2) ? last_d : rnd(32);
         k   = rnd(256);
         a   = rnd(64);
         if (sel < 1)
            issue(op_out, d, 0, 0, a);
         else if (sel < 6)
            issue(two_ops[rnd(9)], d, r, 0, 0);
         else
            issue(imm_ops[rnd(5)], 16 + d % 16, 0, k, 0);
         last_d = (sel < 6) ? d : 16 + d % 16;
      end
      dump_regs();
      end_test("arithmetic and logic");

      for (int i = 0; i < 150; i++)
      begin
         sel = rnd(11);
         d   = 16 + rnd(8);
         r   = 16 + rnd(8);
         k   = rnd(256);
         if (sel < 8)
            issue(one_ops[sel], rnd(32), 0, 0, 0);
         else if (sel == 8)
            issue(op_cp, d, r, 0, 0);
         else if (sel == 9)
            issue(op_cpi, d, 0, k, 0);
         else
         begin
            // Equal operands now and then so the Z chain survives
            issue(op_ldi, d, 0, k, 0);
            issue(op_ldi, r, 0, rnd(2) ? k : rnd(256), 0);
            issue(op_sub, d, r, 0, 0);
            issue(op_sbc, d, d, 0, 0);
            issue(op_sbc, r, r, 0, 0);
         end
      end
      dump_regs();
      end_test("single register and compares");

      stall_pct = 50;
      for (int i = 0; i < 60; i++)
      begin
         k = rnd(256);
         a = rnd(64);
         issue(op_nop, 0, 0, k, a);
      end
      stall_pct = 0;
      dump_regs();
      end_test("unknown codes and stalls");

      $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

/* avr_core.f */
avr_pkg.sv
avr_if.sv
avr_fetch_dec.sv
avr_reg_file.sv
avr_alu_exec.sv
avr_core.sv
tb_avr_core.sv
